/* Bender.yml */
package:
  name: sd_cmd_controller

sources:
  - sd_cmd_pkg.sv
  - sd_clock_divider.sv
  - sd_crc7.sv
  - sd_cmd_serial_host.sv
  - sd_cmd_master.sv
  - sd_cmd_regs.sv
  - sd_cmd_controller.sv
  - target: test
    files:
      - sd_cmd_controller_properties.sv
      - sd_cmd_controller_tb.sv

/* sd_clock_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_clock_divider (
    input  wire        aclk_i,
    input  wire        reset_i,
    input  wire  [7:0] divisor_i,
    output logic       sd_clk_o,
    output logic       sd_rise_o,
    output logic       sd_fall_o
);

    logic [7:0] div_q;
    logic [7:0] cnt_q;
    logic       toggle;

    // Enables mark the cycle whose closing edge moves the pin
    assign toggle    = (cnt_q == div_q);
    assign sd_rise_o = toggle && !sd_clk_o;
    assign sd_fall_o = toggle && sd_clk_o;

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            cnt_q    <= '0;
            div_q    <= '0;
            sd_clk_o <= 1'b0;
        end else if (toggle) begin
            cnt_q    <= '0;
            // Divisor only changes on a level boundary
            div_q    <= divisor_i;
            sd_clk_o <= !sd_clk_o;
        end else begin
            cnt_q <= cnt_q + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* sd_cmd_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_controller import sd_cmd_pkg::*; (
    input  wire         aclk_i,
    input  wire         reset_i,
    input  wire         reg_wr_i,
    input  wire         reg_rd_i,
    input  wire  [3:0]  reg_addr_i,
    input  wire  [31:0] reg_wdata_i,
    output logic [31:0] reg_rdata_o,
    output logic        sd_clk_o,
    input  wire         cmd_i,
    output logic        cmd_o,
    output logic        cmd_oe_o,
    output logic        interrupt_o
);

    logic                busy;
    logic [int_bits-1:0] status_set;
    logic [31:0]         response;
    logic                cmd_start;
    logic [31:0]         argument;
    logic [10:0]         command;
    logic [7:0]          divisor;
    logic                sd_rise;
    logic                sd_fall;
    logic                tx_start;
    cmd_frame_u          tx_frame;
    logic                resp_expect;
    logic                done;
    logic                timeout;
    logic                crc_ok;
    cmd_frame_u          resp_frame;

    sd_cmd_regs regs_i (
        .aclk_i       (aclk_i),
        .reset_i      (reset_i),
        .reg_wr_i     (reg_wr_i),
        .reg_rd_i     (reg_rd_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .busy_i       (busy),
        .status_set_i (status_set),
        .response_i   (response),
        .cmd_start_o  (cmd_start),
        .argument_o   (argument),
        .command_o    (command),
        .divisor_o    (divisor),
        .interrupt_o  (interrupt_o)
    );

    sd_clock_divider clock_divider_i (
        .aclk_i    (aclk_i),
        .reset_i   (reset_i),
        .divisor_i (divisor),
        .sd_clk_o  (sd_clk_o),
        .sd_rise_o (sd_rise),
        .sd_fall_o (sd_fall)
    );

    sd_cmd_master cmd_master_i (
        .aclk_i        (aclk_i),
        .reset_i       (reset_i),
        .start_i       (cmd_start),
        .argument_i    (argument),
        .command_i     (command),
        .busy_o        (busy),
        .tx_start_o    (tx_start),
        .tx_frame_o    (tx_frame),
        .resp_expect_o (resp_expect),
        .done_i        (done),
        .timeout_i     (timeout),
        .crc_ok_i      (crc_ok),
        .resp_frame_i  (resp_frame),
        .status_set_o  (status_set),
        .response_o    (response)
    );

    sd_cmd_serial_host cmd_serial_host_i (
        .aclk_i        (aclk_i),
        .reset_i       (reset_i),
        .sd_rise_i     (sd_rise),
        .sd_fall_i     (sd_fall),
        .start_i       (tx_start),
        .resp_expect_i (resp_expect),
        .frame_i       (tx_frame),
        .cmd_i         (cmd_i),
        .cmd_o         (cmd_o),
        .cmd_oe_o      (cmd_oe_o),
        .done_o        (done),
        .resp_o        (resp_frame),
        .crc_ok_o      (crc_ok),
        .timeout_o     (timeout)
    );

endmodule

`default_nettype wire

/* sd_cmd_controller_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_controller_properties import sd_cmd_pkg::*; (
    input wire                aclk_i,
    input wire                reset_i,
    input wire                cmd_o,
    input wire                cmd_oe_o,
    input wire                interrupt_o,
    input wire                sd_fall_i,
    input wire [int_bits-1:0] int_status_i,
    input wire [int_bits-1:0] int_enable_i
);

    // Released CMD line idles high
    assert property (@(posedge aclk_i) disable iff (reset_i) !cmd_oe_o |-> cmd_o)
        else $error("cmd_o low while cmd_oe_o is low");

    assert property (@(posedge aclk_i) disable iff (reset_i)
                     ((int_status_i & int_enable_i) == '0) |-> !interrupt_o)
        else $error("interrupt_o high with no enabled status bit");

    // Output enable moves only at SD clock falling edges
    assert property (@(posedge aclk_i) disable iff (reset_i)
                     $changed(cmd_oe_o) |-> $past(sd_fall_i))
        else $error("cmd_oe_o changed outside an sd_fall cycle");

endmodule

bind sd_cmd_controller sd_cmd_controller_properties props_i (
    .aclk_i       (aclk_i),
    .reset_i      (reset_i),
    .cmd_o        (cmd_o),
    .cmd_oe_o     (cmd_oe_o),
    .interrupt_o  (interrupt_o),
    .sd_fall_i    (sd_fall),
    .int_status_i (regs_i.int_status_q),
    .int_enable_i (regs_i.int_enable_q)
);

`default_nettype wire

/* sd_cmd_controller_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_controller_tb import sd_cmd_pkg::*; ();

    localparam int clk_period_ns     = 40;
    localparam int cmd_divisor       = 1;
    localparam int max_divisor       = 7;
    localparam int cmd_count         = 6;
    localparam int sd_clocks_per_cmd = 130;
    localparam int watchdog_ns       = 2 * cmd_count * sd_clocks_per_cmd * 2 * (max_divisor + 1)
                                     * clk_period_ns;

    logic        aclk_i;
    logic        reset_i;
    logic        reg_wr_i;
    logic        reg_rd_i;
    logic [3:0]  reg_addr_i;
    logic [31:0] reg_wdata_i;
    logic [31:0] reg_rdata_o;
    logic        sd_clk_o;
    logic        cmd_i;
    logic        cmd_o;
    logic        cmd_oe_o;
    logic        interrupt_o;
    logic [31:0] rng_state;

    sd_cmd_controller DUT (
        .aclk_i      (aclk_i),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr_i),
        .reg_rd_i    (reg_rd_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .sd_clk_o    (sd_clk_o),
        .cmd_i       (cmd_i),
        .cmd_o       (cmd_o),
        .cmd_oe_o    (cmd_oe_o),
        .interrupt_o (interrupt_o)
    );

    initial begin
        aclk_i = 1'b0;
        forever begin
            #(clk_period_ns / 2);
            aclk_i = !aclk_i;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
        $display("Test failed");
        $fatal(1);
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Reference CRC7 for x^7 + x^3 + 1 taken MSB first
    function automatic logic [6:0] crc7_ref(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ 7'h09;
            end
        end
        return crc;
    endfunction

    function automatic logic [frame_len-1:0] make_frame(input logic dir,
                                                        input logic [5:0] index,
                                                        input logic [31:0] payload);
        cmd_frame_u frame;
        frame.fields.start   = 1'b0;
        frame.fields.dir     = dir;
        frame.fields.index   = index;
        frame.fields.payload = payload;
        frame.fields.crc     = '0;
        frame.fields.stop    = 1'b1;
        frame.fields.crc     = crc7_ref(frame.bits[frame_len-1:crc_len+1]);
        return frame.bits;
    endfunction

    function automatic logic [31:0] command_word(input logic [5:0] index, input logic resp,
                                                 input logic crc_chk, input logic idx_chk);
        return (32'(idx_chk) << cmd_idx_chk_bit) | (32'(crc_chk) << cmd_crc_chk_bit)
             | (32'(resp) << cmd_resp_bit) | (32'(index) << cmd_index_lsb);
    endfunction

    task automatic check_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge aclk_i);
        reg_wr_i    = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(negedge aclk_i);
        reg_wr_i = 1'b0;
    endtask

    task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge aclk_i);
        reg_rd_i   = 1'b1;
        reg_addr_i = addr;
        @(negedge aclk_i);
        reg_rd_i = 1'b0;
        data     = reg_rdata_o;
    endtask

    task automatic check_reg(input string name, input logic [3:0] addr,
                             input logic [31:0] exp);
        logic [31:0] data;
        reg_read(addr, data);
        check_value(name, data, exp);
    endtask

    // Busy shows up a cycle after the command strobe
    task automatic wait_command_done();
        logic [31:0] present;
        present = '0;
        while (present[0] == 1'b0) begin
            reg_read(addr_present, present);
        end
        while (present[0] == 1'b1) begin
            reg_read(addr_present, present);
        end
    endtask

    task automatic count_sd_level(output int cycles);
        logic level;
        level  = sd_clk_o;
        cycles = 0;
        do begin
            @(negedge aclk_i);
            cycles++;
        end while (sd_clk_o == level);
    endtask

    task automatic sample_sd_rise(output logic oe, output logic val);
        @(posedge sd_clk_o);
        @(negedge aclk_i);
        oe  = cmd_oe_o;
        val = cmd_o;
    endtask

    // Card model takes the host frame and answers after two SD clocks
    task automatic card_exchange(input logic reply, input logic [47:0] resp,
                                 output logic [47:0] seen);
        logic oe;
        logic val;
        oe = 1'b0;
        while (!oe) begin
            sample_sd_rise(oe, val);
        end
        seen[frame_len-1] = val;
        for (int i = frame_len - 2; i >= 0; i--) begin
            sample_sd_rise(oe, val);
            check_value("cmd_oe_o", oe, 1);
            seen[i] = val;
        end
        if (reply) begin
            repeat (2) @(negedge sd_clk_o);
            for (int i = frame_len - 1; i >= 0; i--) begin
                @(negedge sd_clk_o);
                @(negedge aclk_i);
                cmd_i = resp[i];
            end
        end
    endtask

    task automatic run_command(input logic [31:0] arg, input logic [31:0] cmd,
                               input logic reply, input logic [47:0] resp,
                               input logic poke_busy, output logic [47:0] seen);
        reg_write(addr_argument, arg);
        fork
            card_exchange(reply, resp, seen);
            begin
                reg_write(addr_command, cmd);
                if (poke_busy) begin
                    reg_write(addr_command, ~cmd & 32'h7ff);
                end
                wait_command_done();
            end
        join
    endtask

    task automatic test_reset_state();
        logic [31:0] data;
        reset_i = 1'b1;
        repeat (2) @(posedge aclk_i);
        @(negedge aclk_i);
        check_value("sd_clk_o", sd_clk_o, 0);
        check_value("cmd_o", cmd_o, 1);
        reset_i = 1'b0;
        for (int a = 0; a < 7; a++) begin
            reg_read(4'(a), data);
            check_value("reg_rdata_o", data, 0);
        end
        check_value("interrupt_o", interrupt_o, 0);
        check_value("cmd_oe_o", cmd_oe_o, 0);
    endtask

    task automatic test_clock_divider();
        int divs[3] = '{0, 3, 7};
        int n;
        for (int k = 0; k < 3; k++) begin
            reg_write(addr_divisor, divs[k]);
            // Old divisor may still govern the current level
            count_sd_level(n);
            count_sd_level(n);
            repeat (2) begin
                count_sd_level(n);
                check_value("sd_clk_o level cycles", n, divs[k] + 1);
            end
        end
    endtask

    task automatic test_no_response();
        logic [31:0] arg;
        logic [5:0]  idx;
        logic [47:0] seen;
        arg = next_random();
        idx = 6'(next_random());
        reg_write(addr_divisor, cmd_divisor);
        run_command(arg, command_word(idx, 0, 0, 0), 1'b0, '0, 1'b0, seen);
        check_value("cmd_o frame", seen, make_frame(1'b1, idx, arg));
        check_reg("int_status", addr_int_status, 32'b1 << int_cmd_complete);
        check_reg("present", addr_present, 0);
        check_value("interrupt_o", interrupt_o, 0);
        reg_write(addr_int_enable, 32'b1 << int_cmd_complete);
        check_value("interrupt_o", interrupt_o, 1);
        reg_write(addr_int_enable, 0);
        reg_write(addr_int_status, 32'hf);
    endtask

    task automatic test_short_response();
        logic [31:0] arg;
        logic [31:0] payload;
        logic [5:0]  idx;
        logic [47:0] seen;
        arg     = next_random();
        payload = next_random();
        idx     = 6'(next_random());
        run_command(arg, command_word(idx, 1, 1, 1), 1'b1, make_frame(1'b0, idx, payload),
                    1'b0, seen);
        check_value("cmd_o frame", seen, make_frame(1'b1, idx, arg));
        check_reg("response", addr_response, payload);
        check_reg("int_status", addr_int_status, 32'b1 << int_cmd_complete);
        reg_write(addr_int_status, 32'b1 << int_cmd_complete);
        check_reg("int_status", addr_int_status, 0);
    endtask

    task automatic test_response_errors();
        logic [31:0] arg;
        logic [5:0]  idx;
        logic [47:0] resp;
        logic [47:0] seen;
        arg  = next_random();
        idx  = 6'(next_random());
        // Wrong index and one flipped CRC bit in the same reply
        resp = make_frame(1'b0, idx ^ 6'h01, next_random());
        resp[1] = !resp[1];
        run_command(arg, command_word(idx, 1, 1, 0), 1'b1, resp, 1'b1, seen);
        check_reg("command", addr_command, command_word(idx, 1, 1, 0));
        check_reg("int_status", addr_int_status,
                  (32'b1 << int_cmd_complete) | (32'b1 << int_cmd_crc_err));
        reg_write(addr_int_status, 32'hf);
        run_command(arg, command_word(idx, 1, 0, 1), 1'b1, resp, 1'b0, seen);
        check_reg("int_status", addr_int_status,
                  (32'b1 << int_cmd_complete) | (32'b1 << int_cmd_index_err));
        reg_write(addr_int_status, 32'hf);
    endtask

    task automatic test_silent_card();
        logic [31:0] arg;
        logic [31:0] old_resp;
        logic [5:0]  idx;
        logic [47:0] seen;
        arg = next_random();
        idx = 6'(next_random());
        reg_read(addr_response, old_resp);
        run_command(arg, command_word(idx, 1, 1, 1), 1'b0, '0, 1'b0, seen);
        check_value("cmd_o frame", seen, make_frame(1'b1, idx, arg));
        check_reg("int_status", addr_int_status,
                  (32'b1 << int_cmd_complete) | (32'b1 << int_cmd_timeout));
        check_reg("response", addr_response, old_resp);
    endtask

    initial begin
        reset_i     = 1'b1;
        reg_wr_i    = 1'b0;
        reg_rd_i    = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        cmd_i       = 1'b1;
        rng_state   = 32'h9f3b95b4;
        test_reset_state();
        test_clock_divider();
        test_no_response();
        test_short_response();
        test_response_errors();
        test_silent_card();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sd_cmd_master.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_master import sd_cmd_pkg::*; (
    input  wire                 aclk_i,
    input  wire                 reset_i,
    input  wire                 start_i,
    input  wire  [31:0]         argument_i,
    input  wire  [10:0]         command_i,
    output logic                busy_o,
    output logic                tx_start_o,
    output cmd_frame_u          tx_frame_o,
    output logic                resp_expect_o,
    input  wire                 done_i,
    input  wire                 timeout_i,
    input  wire                 crc_ok_i,
    input  wire cmd_frame_u     resp_frame_i,
    output logic [int_bits-1:0] status_set_o,
    output logic [31:0]         response_o
);

    logic [5:0]  index_q;
    logic [31:0] argument_q;
    logic        crc_chk_q;
    logic        idx_chk_q;
    logic        crc_err;
    logic        idx_err;

    // Host-to-card frame, CRC is filled in by the serial engine
    always_comb begin
        tx_frame_o                = '0;
        tx_frame_o.fields.start   = 1'b0;
        tx_frame_o.fields.dir     = 1'b1;
        tx_frame_o.fields.index   = index_q;
        tx_frame_o.fields.payload = argument_q;
        tx_frame_o.fields.stop    = 1'b1;
    end

    assign crc_err = crc_chk_q && !timeout_i && !crc_ok_i;
    assign idx_err = idx_chk_q && !timeout_i && (resp_frame_i.fields.index != index_q);

    always_ff @(posedge aclk_i) begin
        if (start_i) begin
            index_q    <= command_i[cmd_index_lsb +: 6];
            argument_q <= argument_i;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            busy_o        <= 1'b0;
            tx_start_o    <= 1'b0;
            resp_expect_o <= 1'b0;
            crc_chk_q     <= 1'b0;
            idx_chk_q     <= 1'b0;
            status_set_o  <= '0;
            response_o    <= '0;
        end else begin
            tx_start_o   <= start_i;
            status_set_o <= '0;
            if (start_i) begin
                busy_o        <= 1'b1;
                resp_expect_o <= command_i[cmd_resp_bit];
                crc_chk_q     <= command_i[cmd_crc_chk_bit];
                idx_chk_q     <= command_i[cmd_idx_chk_bit];
            end
            if (done_i) begin
                busy_o                          <= 1'b0;
                status_set_o[int_cmd_complete]  <= 1'b1;
                status_set_o[int_cmd_timeout]   <= timeout_i;
                status_set_o[int_cmd_crc_err]   <= crc_err;
                status_set_o[int_cmd_index_err] <= idx_err;
                // Silent card leaves the last response in place
                if (resp_expect_o && !timeout_i) begin
                    response_o <= resp_frame_i.fields.payload;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sd_cmd_pkg.sv */
`default_nettype none

package sd_cmd_pkg;

    localparam int frame_len    = 48;
    localparam int crc_len      = 7;
    localparam int resp_timeout = 64;

    // Register word addresses
    localparam logic [3:0] addr_argument   = 4'd0;
    localparam logic [3:0] addr_command    = 4'd1;
    localparam logic [3:0] addr_divisor    = 4'd2;
    localparam logic [3:0] addr_response   = 4'd3;
    localparam logic [3:0] addr_int_status = 4'd4;
    localparam logic [3:0] addr_int_enable = 4'd5;
    localparam logic [3:0] addr_present    = 4'd6;

    // Command register layout
    localparam int cmd_index_lsb   = 0;
    localparam int cmd_resp_bit    = 8;
    localparam int cmd_crc_chk_bit = 9;
    localparam int cmd_idx_chk_bit = 10;

    // Interrupt status bits
    localparam int int_cmd_complete  = 0;
    localparam int int_cmd_timeout   = 1;
    localparam int int_cmd_crc_err   = 2;
    localparam int int_cmd_index_err = 3;
    localparam int int_bits          = 4;

    // Serial engine states
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_send    = 2'd1;
    localparam logic [1:0] st_wait    = 2'd2;
    localparam logic [1:0] st_receive = 2'd3;

    // CMD line frame, seen as a shift word or as its fields
    typedef union packed {
        logic [frame_len-1:0] bits;
        struct packed {
            logic               start;
            logic               dir;
            logic [5:0]         index;
            logic [31:0]        payload;
            logic [crc_len-1:0] crc;
            logic               stop;
        } fields;
    } cmd_frame_u;

endpackage

`default_nettype wire

/* sd_cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_regs import sd_cmd_pkg::*; (
    input  wire                 aclk_i,
    input  wire                 reset_i,
    input  wire                 reg_wr_i,
    input  wire                 reg_rd_i,
    input  wire  [3:0]          reg_addr_i,
    input  wire  [31:0]         reg_wdata_i,
    output logic [31:0]         reg_rdata_o,
    input  wire                 busy_i,
    input  wire  [int_bits-1:0] status_set_i,
    input  wire  [31:0]         response_i,
    output logic                cmd_start_o,
    output logic [31:0]         argument_o,
    output logic [10:0]         command_o,
    output logic [7:0]          divisor_o,
    output logic                interrupt_o
);

    logic [int_bits-1:0] int_status_q;
    logic [int_bits-1:0] int_enable_q;
    logic                cmd_wr;
    logic [int_bits-1:0] status_clr;

    // Busy from the master lags the strobe by one cycle
    assign cmd_wr = reg_wr_i && (reg_addr_i == addr_command) && !busy_i && !cmd_start_o;

    assign status_clr = (reg_wr_i && reg_addr_i == addr_int_status)
                      ? reg_wdata_i[int_bits-1:0] : '0;

    assign interrupt_o = |(int_status_q & int_enable_q);

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            argument_o   <= '0;
            command_o    <= '0;
            divisor_o    <= '0;
            int_enable_q <= '0;
            cmd_start_o  <= 1'b0;
        end else begin
            cmd_start_o <= cmd_wr;
            if (cmd_wr) begin
                command_o <= reg_wdata_i[10:0];
            end
            if (reg_wr_i) begin
                case (reg_addr_i)
                    addr_argument:   argument_o   <= reg_wdata_i;
                    addr_divisor:    divisor_o    <= reg_wdata_i[7:0];
                    addr_int_enable: int_enable_q <= reg_wdata_i[int_bits-1:0];
                    default: ;
                endcase
            end
        end
    end

    // New events win over a clear in the same cycle
    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            int_status_q <= '0;
        end else begin
            int_status_q <= (int_status_q & ~status_clr) | status_set_i;
        end
    end

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            reg_rdata_o <= '0;
        end else if (reg_rd_i) begin
            case (reg_addr_i)
                addr_argument:   reg_rdata_o <= argument_o;
                addr_command:    reg_rdata_o <= {21'b0, command_o};
                addr_divisor:    reg_rdata_o <= {24'b0, divisor_o};
                addr_response:   reg_rdata_o <= response_i;
                addr_int_status: reg_rdata_o <= {{(32-int_bits){1'b0}}, int_status_q};
                addr_int_enable: reg_rdata_o <= {{(32-int_bits){1'b0}}, int_enable_q};
                // Command inhibit
                addr_present:    reg_rdata_o <= {31'b0, busy_i};
                default:         reg_rdata_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* sd_cmd_serial_host.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_serial_host import sd_cmd_pkg::*; (
    input  wire             aclk_i,
    input  wire             reset_i,
    input  wire             sd_rise_i,
    input  wire             sd_fall_i,
    input  wire             start_i,
    input  wire             resp_expect_i,
    input  wire cmd_frame_u frame_i,
    input  wire             cmd_i,
    output logic            cmd_o,
    output logic            cmd_oe_o,
    output logic            done_o,
    output cmd_frame_u      resp_o,
    output logic            crc_ok_o,
    output logic            timeout_o
);

    logic [1:0]           state_q;
    logic [frame_len-1:0] shift_q;
    logic [5:0]           bit_cnt_q;
    logic [6:0]           wait_cnt_q;
    logic                 resp_exp_q;
    logic                 crc_clear;
    logic                 crc_shift;
    logic                 crc_bit;
    logic [crc_len-1:0]   crc;
    logic                 in_crc_field;
    logic [2:0]           crc_sel;
    logic                 tx_bit;

    // Bits 47..8 feed the CRC, bits 7..1 carry it
    assign in_crc_field = (bit_cnt_q >= 6'(frame_len - crc_len - 1))
                       && (bit_cnt_q < 6'(frame_len - 1));
    assign crc_sel      = 3'(frame_len - 2 - int'(bit_cnt_q));
    assign tx_bit       = in_crc_field ? crc[crc_sel] : shift_q[frame_len-1];

    assign crc_clear = (state_q == st_idle)
                    || (state_q == st_send && sd_fall_i && bit_cnt_q == 6'(frame_len));
    assign crc_shift = (state_q == st_send && sd_fall_i
                        && bit_cnt_q < 6'(frame_len - crc_len - 1))
                    || (state_q == st_wait && sd_rise_i && !cmd_i)
                    || (state_q == st_receive && sd_rise_i
                        && bit_cnt_q < 6'(frame_len - crc_len - 1));
    assign crc_bit   = (state_q == st_send) ? shift_q[frame_len-1] : cmd_i;

    assign resp_o.bits = shift_q;

    sd_crc7 crc7_i (
        .aclk_i  (aclk_i),
        .reset_i (reset_i),
        .clear_i (crc_clear),
        .shift_i (crc_shift),
        .bit_i   (crc_bit),
        .crc_o   (crc)
    );

    always_ff @(posedge aclk_i) begin
        if (state_q == st_idle && start_i) begin
            shift_q <= frame_i.bits;
        end else if (state_q == st_send && sd_fall_i) begin
            shift_q <= {shift_q[frame_len-2:0], 1'b0};
        end else if (sd_rise_i && ((state_q == st_wait && !cmd_i) || state_q == st_receive)) begin
            shift_q <= {shift_q[frame_len-2:0], cmd_i};
        end
    end

    always_ff @(posedge aclk_i) begin
        if (reset_i) begin
            state_q    <= st_idle;
            bit_cnt_q  <= '0;
            wait_cnt_q <= '0;
            resp_exp_q <= 1'b0;
            cmd_o      <= 1'b1;
            cmd_oe_o   <= 1'b0;
            done_o     <= 1'b0;
            timeout_o  <= 1'b0;
            crc_ok_o   <= 1'b0;
        end else begin
            done_o    <= 1'b0;
            timeout_o <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start_i) begin
                        resp_exp_q <= resp_expect_i;
                        bit_cnt_q  <= '0;
                        state_q    <= st_send;
                    end
                end
                st_send: begin
                    if (sd_fall_i) begin
                        if (bit_cnt_q == 6'(frame_len)) begin
                            // End bit done, release the line
                            cmd_o      <= 1'b1;
                            cmd_oe_o   <= 1'b0;
                            wait_cnt_q <= '0;
                            if (resp_exp_q) begin
                                state_q <= st_wait;
                            end else begin
                                done_o  <= 1'b1;
                                state_q <= st_idle;
                            end
                        end else begin
                            cmd_o     <= tx_bit;
                            cmd_oe_o  <= 1'b1;
                            bit_cnt_q <= bit_cnt_q + 6'd1;
                        end
                    end
                end
                st_wait: begin
                    if (sd_rise_i) begin
                        if (!cmd_i) begin
                            bit_cnt_q <= 6'd1;
                            state_q   <= st_receive;
                        end else if (wait_cnt_q == 7'(resp_timeout - 1)) begin
                            done_o    <= 1'b1;
                            timeout_o <= 1'b1;
                            state_q   <= st_idle;
                        end else begin
                            wait_cnt_q <= wait_cnt_q + 7'd1;
                        end
                    end
                end
                default: begin
                    if (sd_rise_i) begin
                        bit_cnt_q <= bit_cnt_q + 6'd1;
                        if (bit_cnt_q == 6'(frame_len - 1)) begin
                            // Received CRC sits in the low bits before the end bit
                            crc_ok_o <= (shift_q[crc_len-1:0] == crc);
                            done_o   <= 1'b1;
                            state_q  <= st_idle;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* sd_crc7.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_crc7 import sd_cmd_pkg::*; (
    input  wire                aclk_i,
    input  wire                reset_i,
    input  wire                clear_i,
    input  wire                shift_i,
    input  wire                bit_i,
    output logic [crc_len-1:0] crc_o
);

    logic feedback;

    assign feedback = bit_i ^ crc_o[crc_len-1];

    // x^7 + x^3 + 1
    always_ff @(posedge aclk_i) begin
        if (reset_i || clear_i) begin
            crc_o <= '0;
        end else if (shift_i) begin
            crc_o    <= {crc_o[crc_len-2:0], 1'b0};
            crc_o[0] <= feedback;
            crc_o[3] <= crc_o[2] ^ feedback;
        end
    end

endmodule

`default_nettype wire

/* src.f */
sd_cmd_pkg.sv
sd_clock_divider.sv
sd_crc7.sv
sd_cmd_serial_host.sv
sd_cmd_master.sv
sd_cmd_regs.sv
sd_cmd_controller.sv
sd_cmd_controller_properties.sv
sd_cmd_controller_tb.sv
